// File: src/graph_defs.svh
// Widths and buffer sizes for the sum compute unit, included by every RTL file that needs them

`ifndef GRAPH_DEFS_SVH
`define GRAPH_DEFS_SVH

////////////////////
// Graph data widths
////////////////////

// Vertex identifier
`define VERTEX_ID_BITS 16

// In-degree and the edge counters
`define DEGREE_BITS 16

// One edge value, and one vertex sum
`define EDGE_DATA_BITS 32

////////////////////
// Memory side
////////////////////

`define ADDRESS_BITS 32

// Four 32-bit slots per line
`define CACHELINE_BITS 128

// Tag of the issuing compute unit
`define CU_ID_BITS 8

////////////////////
// Buffer depths
////////////////////

`define FIFO_DEPTH_EDGE 16
`define FIFO_DEPTH_JOB 8

`endif

// File: src/graph_types_pkg.sv
// Graph-side types shared by the kernel, the edge stream and the top level of the sum unit

`include "graph_defs.svh"

package graph_types_pkg;

	////////////////////
	// Vertex jobs
	////////////////////

	// One job per vertex, pushed by the host
	typedef struct packed {
		logic [`VERTEX_ID_BITS-1:0] id;
		logic [`DEGREE_BITS-1:0]    degree;
	} vertex_job_t;

	////////////////////
	// Edge stream
	////////////////////

	// Valid bit travels with the value through the latch stage
	typedef struct packed {
		logic                       valid;
		logic [`EDGE_DATA_BITS-1:0] data;
	} edge_word_t;

	////////////////////
	// Kernel FSM
	////////////////////

	// Idle fetches a job, accumulate sums its edges, emit issues the write
	typedef enum logic [1:0] {
		KERNEL_IDLE       = 2'd0,
		KERNEL_ACCUMULATE = 2'd1,
		KERNEL_EMIT       = 2'd2
	} kernel_state_t;

endpackage

// File: src/mem_cmd_pkg.sv
// Memory write command types, driven by the kernel and flattened to ports at the top level

`include "graph_defs.svh"

package mem_cmd_pkg;

	// Slot index within a cache line
	localparam int SLOT_BITS = $clog2(`CACHELINE_BITS / `EDGE_DATA_BITS);

	////////////////////
	// Opcodes
	////////////////////

	// Encodings follow the host bus write commands
	typedef enum logic [12:0] {
		WRITE_NA = 13'h0D00,
		WRITE_MS = 13'h0D70
	} write_opcode_t;

	////////////////////
	// Write command
	////////////////////

	typedef struct packed {
		logic                       valid;
		write_opcode_t              opcode;
		logic [`ADDRESS_BITS-1:0]   address;
		logic [`VERTEX_ID_BITS-1:0] vertex_id;
		logic [SLOT_BITS-1:0]       slot;
		// Issuing compute unit
		logic [`CU_ID_BITS-1:0]     cu_id;
		// Sum sits in its slot, other slots are zero
		logic [`CACHELINE_BITS-1:0] data;
	} write_command_t;

endpackage

// File: src/edge_stream_if.sv
// Edge stream between the edge buffer and the kernel, used through its buffer and kernel modports

`timescale 1ns/100ps

interface edge_stream_if;

	// Kernel asks for a word while the buffer is not empty
	logic request;
	logic empty;

	// Popped word, one cycle after the request
	graph_types_pkg::edge_word_t edge_word;
	logic pop_valid;

	modport buffer (
		input  request,
		output empty,
		output edge_word,
		output pop_valid
	);

	modport kernel (
		output request,
		input  empty,
		input  edge_word,
		input  pop_valid
	);

endinterface

// File: src/sync_fifo.sv
// Synchronous circular buffer, instantiated for vertex jobs and for edge values

`timescale 1ns/100ps

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	input  logic             pop,
	output logic [WIDTH-1:0] pop_data,
	output logic             pop_valid,
	output logic             empty,
	output logic             full
);

	localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [PTR_BITS-1:0]   write_ptr;
	logic [PTR_BITS-1:0]   read_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	// Drop pushes while full and pops while empty
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty = (count == '0);
	assign full  = (count == COUNT_BITS'(DEPTH));

	////////////////////
	// Pointers and occupancy
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_ptr <= '0;
			read_ptr  <= '0;
			count     <= '0;
			pop_valid <= 1'b0;
		end else begin
			if (do_push) begin
				write_ptr <= (write_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
			end
			if (do_pop) begin
				read_ptr <= (read_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			pop_valid <= do_pop;
		end
	end

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[write_ptr] <= push_data;
		end
	end

	// Read data registered, valid alongside pop_valid
	always_ff @(posedge clock) begin
		if (do_pop) begin
			pop_data <= mem[read_ptr];
		end
	end

endmodule

// File: src/sum_kernel_control.sv
// Sum kernel: adds in-degree edge values per vertex job and issues one memory write per vertex

`timescale 1ns/100ps

`include "graph_defs.svh"

module sum_kernel_control #(
	parameter int CU_ID = 0
) (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                enabled_in,
	edge_stream_if.kernel                       edges,
	output logic                                job_pop,
	input  graph_types_pkg::vertex_job_t        job,
	input  logic                                job_valid,
	input  logic [`ADDRESS_BITS-1:0]            base_address,
	input  logic                                use_ms,
	input  logic                                wr_rsp_valid,
	output mem_cmd_pkg::write_command_t         write_command,
	output logic [`DEGREE_BITS-1:0]             edge_count,
	output logic [`DEGREE_BITS-1:0]             vertex_done_count
);

	localparam int BYTE_COUNT = `EDGE_DATA_BITS / 8;
	// Address step per vertex is one edge-sized word
	localparam int ADDR_SHIFT = $clog2(BYTE_COUNT);

	logic                                enabled;
	logic                                can_pop;
	graph_types_pkg::kernel_state_t      state;
	logic                                job_wait;
	graph_types_pkg::vertex_job_t        job_latched;
	graph_types_pkg::edge_word_t         edge_latched;
	logic [`EDGE_DATA_BITS-1:0]          sum;
	logic [`DEGREE_BITS-1:0]             accum_count;
	logic [`DEGREE_BITS-1:0]             issued_count;
	logic                                count_done;
	logic [mem_cmd_pkg::SLOT_BITS-1:0]   slot;
	mem_cmd_pkg::write_command_t         cmd_next;

	// Host byte order on the write line
	function automatic logic [`EDGE_DATA_BITS-1:0] swap_bytes(
		input logic [`EDGE_DATA_BITS-1:0] value
	);
		logic [`EDGE_DATA_BITS-1:0] swapped;
		for (int i = 0; i < BYTE_COUNT; i++) begin
			swapped[i*8 +: 8] = value[(BYTE_COUNT-1-i)*8 +: 8];
		end
		return swapped;
	endfunction

	////////////////////
	// Enable
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	// A pop issued now returns in a cycle that is still enabled
	assign can_pop = enabled && enabled_in;

	////////////////////
	// Pop requests
	////////////////////

	// Retry every other cycle until the job buffer answers
	assign job_pop = can_pop && (state == graph_types_pkg::KERNEL_IDLE) && !job_wait;

	// Never fetch past this job's in-degree
	assign edges.request = can_pop && (state == graph_types_pkg::KERNEL_ACCUMULATE)
		&& !edges.empty && (issued_count != job_latched.degree);

	assign count_done = (accum_count == job_latched.degree);

	////////////////////
	// FSM
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state    <= graph_types_pkg::KERNEL_IDLE;
			job_wait <= 1'b0;
		end else if (enabled) begin
			job_wait <= job_pop;
			case (state)
				graph_types_pkg::KERNEL_IDLE: begin
					if (job_valid) begin
						state <= graph_types_pkg::KERNEL_ACCUMULATE;
					end
				end
				graph_types_pkg::KERNEL_ACCUMULATE: begin
					if (count_done) begin
						state <= graph_types_pkg::KERNEL_EMIT;
					end
				end
				default: begin
					state <= graph_types_pkg::KERNEL_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (enabled && (state == graph_types_pkg::KERNEL_IDLE) && job_valid) begin
			job_latched <= job;
		end
	end

	////////////////////
	// Edge latch and sum
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_latched <= '0;
		end else if (enabled) begin
			if (edges.pop_valid) begin
				edge_latched <= edges.edge_word;
			end else begin
				edge_latched <= '0;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sum          <= '0;
			accum_count  <= '0;
			issued_count <= '0;
		end else if (enabled) begin
			if (edges.request) begin
				issued_count <= issued_count + 1'b1;
			end
			if (edge_latched.valid) begin
				sum         <= sum + edge_latched.data;
				accum_count <= accum_count + 1'b1;
			end
			// Clear for the next vertex once the command is formed
			if (state == graph_types_pkg::KERNEL_EMIT) begin
				sum          <= '0;
				accum_count  <= '0;
				issued_count <= '0;
			end
		end
	end

	////////////////////
	// Write command
	////////////////////

	always_comb begin
		cmd_next = '0;
		slot     = job_latched.id[mem_cmd_pkg::SLOT_BITS-1:0];
		if (enabled && (state == graph_types_pkg::KERNEL_EMIT)) begin
			cmd_next.valid     = 1'b1;
			cmd_next.opcode    = use_ms ? mem_cmd_pkg::WRITE_MS : mem_cmd_pkg::WRITE_NA;
			cmd_next.address   = base_address + (`ADDRESS_BITS'(job_latched.id) << ADDR_SHIFT);
			cmd_next.vertex_id = job_latched.id;
			cmd_next.slot      = slot;
			cmd_next.cu_id     = `CU_ID_BITS'(CU_ID);
			cmd_next.data[slot*`EDGE_DATA_BITS +: `EDGE_DATA_BITS] = swap_bytes(sum);
		end
	end

	// Valid for one cycle only, even if the enable drops right after emit
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_command <= '0;
		end else begin
			write_command <= cmd_next;
		end
	end

	////////////////////
	// Counters
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_count <= '0;
		end else if (enabled && edge_latched.valid) begin
			edge_count <= edge_count + 1'b1;
		end
	end

	// Responses land whatever the enable, so every pulse counts
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_count <= '0;
		end else if (wr_rsp_valid) begin
			vertex_done_count <= vertex_done_count + 1'b1;
		end
	end

endmodule

// File: src/cu_sum_unit.sv
// Top level of the sum compute unit: job and edge buffers feeding the kernel, with plain ports

`timescale 1ns/100ps

`include "graph_defs.svh"

module cu_sum_unit #(
	parameter int CU_ID = 0
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled_in,
	input  logic                         job_push,
	input  logic [`VERTEX_ID_BITS-1:0]   job_id,
	input  logic [`DEGREE_BITS-1:0]      job_degree,
	output logic                         job_full,
	input  logic                         edge_push,
	input  logic [`EDGE_DATA_BITS-1:0]   edge_value,
	output logic                         edge_full,
	input  logic [`ADDRESS_BITS-1:0]     base_address,
	input  logic                         use_ms,
	output logic                         wr_cmd_valid,
	output mem_cmd_pkg::write_opcode_t   wr_cmd_opcode,
	output logic [`ADDRESS_BITS-1:0]     wr_cmd_address,
	output logic [`CACHELINE_BITS-1:0]   wr_cmd_data,
	input  logic                         wr_rsp_valid,
	output logic [`DEGREE_BITS-1:0]      edge_count,
	output logic [`DEGREE_BITS-1:0]      vertex_done_count
);

	graph_types_pkg::vertex_job_t  job_push_word;
	graph_types_pkg::vertex_job_t  job_pop_word;
	logic                          job_pop;
	logic                          job_pop_valid;
	logic [`EDGE_DATA_BITS-1:0]    edge_pop_data;
	mem_cmd_pkg::write_command_t   write_command;

	edge_stream_if edges ();

	assign job_push_word.id     = job_id;
	assign job_push_word.degree = job_degree;

	////////////////////
	// Buffers
	////////////////////

	sync_fifo #(
		.WIDTH($bits(graph_types_pkg::vertex_job_t)),
		.DEPTH(`FIFO_DEPTH_JOB)
	) job_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (job_push),
		.push_data(job_push_word),
		.pop      (job_pop),
		.pop_data (job_pop_word),
		.pop_valid(job_pop_valid),
		.empty    (),
		.full     (job_full)
	);

	sync_fifo #(
		.WIDTH(`EDGE_DATA_BITS),
		.DEPTH(`FIFO_DEPTH_EDGE)
	) edge_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (edge_push),
		.push_data(edge_value),
		.pop      (edges.request),
		.pop_data (edge_pop_data),
		.pop_valid(edges.pop_valid),
		.empty    (edges.empty),
		.full     (edge_full)
	);

	assign edges.edge_word = {edges.pop_valid, edge_pop_data};

	////////////////////
	// Kernel
	////////////////////

	sum_kernel_control #(
		.CU_ID(CU_ID)
	) kernel (
		.clock            (clock),
		.rstn             (rstn),
		.enabled_in       (enabled_in),
		.edges            (edges.kernel),
		.job_pop          (job_pop),
		.job              (job_pop_word),
		.job_valid        (job_pop_valid),
		.base_address     (base_address),
		.use_ms           (use_ms),
		.wr_rsp_valid     (wr_rsp_valid),
		.write_command    (write_command),
		.edge_count       (edge_count),
		.vertex_done_count(vertex_done_count)
	);

	// Command out as plain ports
	assign wr_cmd_valid   = write_command.valid;
	assign wr_cmd_opcode  = write_command.opcode;
	assign wr_cmd_address = write_command.address;
	assign wr_cmd_data    = write_command.data;

endmodule

// File: bench/tb_cu_sum_unit.sv
// Drives random vertex jobs into the sum compute unit and checks each write command against a reference model

`timescale 1ns/100ps

`include "graph_defs.svh"

module tb_cu_sum_unit;

	localparam int WAIT_LIMIT   = 2000;
	localparam int DONE_LIMIT   = 10000;
	localparam int QUIET_CYCLES = 100;
	localparam int MAX_DEGREE   = 8;

	typedef struct packed {
		mem_cmd_pkg::write_opcode_t opcode;
		logic [`ADDRESS_BITS-1:0]   address;
		logic [`CACHELINE_BITS-1:0] data;
	} expected_write_t;

	logic                        clock = 1'b0;
	logic                        rstn;
	logic                        enabled_in;
	logic                        job_push;
	logic [`VERTEX_ID_BITS-1:0]  job_id;
	logic [`DEGREE_BITS-1:0]     job_degree;
	logic                        job_full;
	logic                        edge_push;
	logic [`EDGE_DATA_BITS-1:0]  edge_value;
	logic                        edge_full;
	logic [`ADDRESS_BITS-1:0]    base_address;
	logic                        use_ms;
	logic                        wr_cmd_valid;
	mem_cmd_pkg::write_opcode_t  wr_cmd_opcode;
	logic [`ADDRESS_BITS-1:0]    wr_cmd_address;
	logic [`CACHELINE_BITS-1:0]  wr_cmd_data;
	logic                        wr_rsp_valid = 1'b0;
	logic [`DEGREE_BITS-1:0]     edge_count;
	logic [`DEGREE_BITS-1:0]     vertex_done_count;

	int              seed = 46630;
	string           test_name = "reset";
	expected_write_t expected_q [$];
	int              cmd_count = 0;
	int              total_jobs = 0;
	int              total_edges = 0;
	logic [1:0]      rsp_delay = 2'b00;

	always #5 clock = ~clock;

	cu_sum_unit DUT (
		.clock            (clock),
		.rstn             (rstn),
		.enabled_in       (enabled_in),
		.job_push         (job_push),
		.job_id           (job_id),
		.job_degree       (job_degree),
		.job_full         (job_full),
		.edge_push        (edge_push),
		.edge_value       (edge_value),
		.edge_full        (edge_full),
		.base_address     (base_address),
		.use_ms           (use_ms),
		.wr_cmd_valid     (wr_cmd_valid),
		.wr_cmd_opcode    (wr_cmd_opcode),
		.wr_cmd_address   (wr_cmd_address),
		.wr_cmd_data      (wr_cmd_data),
		.wr_rsp_valid     (wr_rsp_valid),
		.edge_count       (edge_count),
		.vertex_done_count(vertex_done_count)
	);

	////////////////////
	// Reference model
	////////////////////

	// Sum of the edges, byte-swapped into slot id mod 4, written at base plus id times four
	function automatic expected_write_t ref_write(
		input logic [`VERTEX_ID_BITS-1:0] id,
		input int                         degree,
		input logic [`EDGE_DATA_BITS-1:0] values [MAX_DEGREE],
		input logic [`ADDRESS_BITS-1:0]   base,
		input logic                       ms
	);
		expected_write_t            result;
		logic [`EDGE_DATA_BITS-1:0] total;
		logic [`EDGE_DATA_BITS-1:0] swapped;
		int                         slot;
		total = '0;
		for (int i = 0; i < degree; i++) begin
			total = total + values[i];
		end
		swapped        = {total[7:0], total[15:8], total[23:16], total[31:24]};
		slot           = int'(id) % 4;
		result.opcode  = ms ? mem_cmd_pkg::WRITE_MS : mem_cmd_pkg::WRITE_NA;
		result.address = base + `ADDRESS_BITS'(id) * 32'd4;
		result.data    = '0;
		result.data[slot*`EDGE_DATA_BITS +: `EDGE_DATA_BITS] = swapped;
		return result;
	endfunction

	////////////////////
	// Checks
	////////////////////

	task automatic report_failure(input string msg);
		$display("ERROR: %s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_value(
		input string                      name,
		input logic [`CACHELINE_BITS-1:0] expected,
		input logic [`CACHELINE_BITS-1:0] actual
	);
		if (expected !== actual) begin
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	task automatic push_job_word(
		input logic [`VERTEX_ID_BITS-1:0] id,
		input logic [`DEGREE_BITS-1:0]    degree
	);
		int n;
		n = 0;
		while (job_full && n < WAIT_LIMIT) begin
			@(negedge clock);
			n++;
		end
		if (job_full) begin
			report_failure("job buffer stayed full");
		end
		job_id     = id;
		job_degree = degree;
		job_push   = 1'b1;
		@(negedge clock);
		job_push = 1'b0;
	endtask

	task automatic push_edge_word(input logic [`EDGE_DATA_BITS-1:0] value);
		int n;
		n = 0;
		while (edge_full && n < WAIT_LIMIT) begin
			@(negedge clock);
			n++;
		end
		if (edge_full) begin
			report_failure("edge buffer stayed full");
		end
		edge_value = value;
		edge_push  = 1'b1;
		@(negedge clock);
		edge_push = 1'b0;
	endtask

	// Edges go either after the job or ahead of it
	task automatic push_job(
		input logic [`VERTEX_ID_BITS-1:0] id,
		input int                         degree,
		input logic                       edges_first
	);
		logic [`EDGE_DATA_BITS-1:0] values [MAX_DEGREE];
		for (int i = 0; i < degree; i++) begin
			values[i] = $random(seed);
		end
		expected_q.push_back(ref_write(id, degree, values, base_address, use_ms));
		total_jobs++;
		total_edges += degree;
		if (!edges_first) begin
			push_job_word(id, `DEGREE_BITS'(degree));
		end
		for (int i = 0; i < degree; i++) begin
			push_edge_word(values[i]);
		end
		if (edges_first) begin
			push_job_word(id, `DEGREE_BITS'(degree));
		end
	endtask

	task automatic wait_all_done();
		int n;
		n = 0;
		while ((expected_q.size() != 0
			|| vertex_done_count != `DEGREE_BITS'(total_jobs)) && n < DONE_LIMIT) begin
			@(negedge clock);
			n++;
		end
		if (expected_q.size() != 0) begin
			report_failure("timed out waiting for write commands");
		end else if (vertex_done_count != `DEGREE_BITS'(total_jobs)) begin
			report_failure("timed out waiting for write responses");
		end
		check_value({test_name, " edge_count"}, 128'(total_edges), 128'(edge_count));
		check_value({test_name, " vertex_done_count"}, 128'(total_jobs),
			128'(vertex_done_count));
	endtask

	////////////////////
	// Response model and compare
	////////////////////

	// Each command is answered two cycles later
	always @(negedge clock) begin
		wr_rsp_valid = rsp_delay[1];
		rsp_delay    = {rsp_delay[0], rstn && wr_cmd_valid};
	end

	always @(negedge clock) begin
		expected_write_t exp_write;
		if (rstn && wr_cmd_valid) begin
			if (expected_q.size() == 0) begin
				report_failure("write command issued with no job pending");
			end else begin
				// Oldest expected entry in job order
				exp_write = expected_q.pop_front();
				check_value({test_name, " opcode"}, 128'(exp_write.opcode), 128'(wr_cmd_opcode));
				check_value({test_name, " address"}, 128'(exp_write.address),
					128'(wr_cmd_address));
				check_value({test_name, " data"}, exp_write.data, wr_cmd_data);
				cmd_count++;
			end
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int n;
		int degree;
		int cmds_before;
		rstn         = 1'b0;
		enabled_in   = 1'b1;
		job_push     = 1'b0;
		job_id       = '0;
		job_degree   = '0;
		edge_push    = 1'b0;
		edge_value   = '0;
		base_address = 32'h0010_0000;
		use_ms       = 1'b0;
		repeat (4) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		check_value("reset wr_cmd_valid", 128'(0), 128'(wr_cmd_valid));
		check_value("reset edge_count", 128'(0), 128'(edge_count));
		check_value("reset vertex_done_count", 128'(0), 128'(vertex_done_count));
		check_value("reset job_full", 128'(0), 128'(job_full));
		check_value("reset edge_full", 128'(0), 128'(edge_full));

		test_name = "single_vertex";
		push_job(16'd13, 1, 1'b0);
		wait_all_done();

		test_name    = "random_jobs_na";
		base_address = 32'h2000_0000;
		for (int i = 0; i < 30; i++) begin
			degree = 1 + int'($unsigned($random(seed)) % MAX_DEGREE);
			push_job(16'($random(seed)), degree, 1'b0);
		end
		wait_all_done();

		test_name    = "random_jobs_ms";
		use_ms       = 1'b1;
		base_address = $random(seed);
		for (int i = 0; i < 12; i++) begin
			degree = 1 + int'($unsigned($random(seed)) % MAX_DEGREE);
			push_job(16'($random(seed)), degree, 1'b0);
		end
		wait_all_done();

		test_name    = "edges_first";
		use_ms       = 1'b0;
		base_address = 32'h0400_0040;
		for (int i = 0; i < 10; i++) begin
			degree = 1 + int'($unsigned($random(seed)) % MAX_DEGREE);
			push_job(16'($random(seed)), degree, 1'b1);
		end
		wait_all_done();

		// Work stays parked in the buffers while the unit is off, filling both
		test_name   = "disabled";
		enabled_in  = 1'b0;
		use_ms      = 1'b1;
		cmds_before = cmd_count;
		for (int i = 0; i < `FIFO_DEPTH_JOB; i++) begin
			push_job(16'($random(seed)), `FIFO_DEPTH_EDGE / `FIFO_DEPTH_JOB, 1'b0);
		end
		for (n = 0; n < QUIET_CYCLES; n++) begin
			@(negedge clock);
		end
		check_value("disabled command count", 128'(cmds_before), 128'(cmd_count));
		check_value("disabled job_full", 128'(1), 128'(job_full));
		check_value("disabled edge_full", 128'(1), 128'(edge_full));
		enabled_in = 1'b1;
		wait_all_done();

		$display("TB PASSED");
		$finish;
	end

endmodule

// File: list.f
+incdir+src
src/graph_types_pkg.sv
src/mem_cmd_pkg.sv
src/edge_stream_if.sv
src/sync_fifo.sv
src/sum_kernel_control.sv
src/cu_sum_unit.sv
bench/tb_cu_sum_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sum unit testbench with Verilator, then look for the pass line in the log

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_EXE=tb_cu_sum_unit_sim

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

verilator --binary --timing -f list.f --top-module tb_cu_sum_unit \
	-Mdir "$BUILD_DIR" -o "$SIM_EXE"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

grep -qx "TB PASSED" "$LOG_FILE"
if [ $? -ne 0 ]; then
	echo "Pass line not found in $LOG_FILE"
	exit 1
fi

echo "Simulation passed"
exit 0
